// File: common/simon_pkg.sv
`default_nettype none

package simon_pkg;

	typedef enum logic [1:0] {
		color_green  = 2'd0,
		color_red    = 2'd1,
		color_blue   = 2'd2,
		color_yellow = 2'd3
	} color_t;

	// note k belongs to colour k
	typedef enum logic [1:0] {
		note_a3  = 2'd0,
		note_b3  = 2'd1,
		note_cs4 = 2'd2,
		note_d4  = 2'd3
	} note_t;

	typedef enum logic [3:0] {
		st_idle,
		st_seed,
		st_gap,
		st_play,
		st_rest,
		st_chk_round,
		st_listen,
		st_echo,
		st_validate,
		st_chk_player,
		st_fanfare,
		st_lose
	} game_state_t;

	typedef logic [11:0] ticks_t;
	typedef logic [7:0]  round_t;

	typedef struct packed {
		logic [3:0] held;
		logic       single;
		color_t     color;
	} buttons_t;

	typedef struct packed {
		logic   led_on;
		color_t led_color;
		logic   tone_on;
		note_t  tone;
		logic   loser;
	} panel_t;

	localparam ticks_t debounce_ticks     = 12'd8;
	localparam ticks_t play_gap_ticks     = 12'd40;
	localparam ticks_t play_note_ticks    = 12'd300;
	localparam ticks_t play_rest_ticks    = 12'd100;
	localparam ticks_t fanfare_note_ticks = 12'd160;
	localparam ticks_t fanfare_gap_ticks  = 12'd20;
	localparam ticks_t lose_first_ticks   = 12'd600;
	localparam ticks_t lose_note_ticks    = 12'd300;
	localparam ticks_t lose_gap_ticks     = 12'd10;
	localparam ticks_t end_pause_ticks    = 12'd400;

	localparam logic [3:0]  lose_notes      = 4'd10;
	localparam logic [3:0]  fanfare_notes   = 4'd4;
	localparam logic [15:0] prng_reset_seed = 16'hb5e3;

	localparam note_t lose_melody [lose_notes] = '{
		note_b3, note_cs4, note_d4, note_d4, note_d4,
		note_cs4, note_a3, note_cs4, note_cs4, note_b3
	};

	localparam color_t fanfare_colors [fanfare_notes] = '{
		color_green, color_red, color_blue, color_yellow
	};

endpackage

`default_nettype wire

// File: rtl/game_timer.sv
`timescale 1ns/10ps
`default_nettype none

module game_timer #(
	parameter int unsigned cycles_per_tick = 50000
) (
	input  wire               clk,
	input  wire               loser_timer_reset,
	input  wire               start,
	input  wire simon_pkg::ticks_t length,
	output logic              tick,
	output logic              done
);
	import simon_pkg::*;

	logic [$clog2(cycles_per_tick + 1)-1:0] pre_cnt;
	ticks_t tick_cnt;

	assign tick = (pre_cnt == $bits(pre_cnt)'(cycles_per_tick - 1));

	// free running prescaler
	always_ff @(posedge clk) begin
		if (loser_timer_reset || tick) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// counts ticks since start, parks at length
	always_ff @(posedge clk) begin
		if (loser_timer_reset || start) begin
			tick_cnt <= '0;
			done <= 1'b0;
		end else begin
			if (tick && tick_cnt != length) begin
				tick_cnt <= tick_cnt + 12'd1;
			end
			done <= (tick_cnt == length);
		end
	end

endmodule

`default_nettype wire

// File: rtl/button_debouncer.sv
`timescale 1ns/10ps
`default_nettype none

module button_debouncer (
	input  wire        clk,
	input  wire        loser_timer_reset,
	input  wire        tick,
	input  wire [3:0]  btn_n,
	output simon_pkg::buttons_t buttons
);
	import simon_pkg::*;

	logic [3:0] sync_0;
	logic [3:0] sync_1;
	logic [3:0] held;
	ticks_t     stable_cnt [4];
	color_t     color;

	// buttons are active low, bring them in as active high
	always_ff @(posedge clk) begin
		sync_0 <= ~btn_n;
		sync_1 <= sync_0;
	end

	always_ff @(posedge clk) begin
		if (loser_timer_reset) begin
			held <= '0;
			for (int k = 0; k < 4; k++) begin
				stable_cnt[k] <= '0;
			end
		end else begin
			for (int k = 0; k < 4; k++) begin
				if (sync_1[k] == held[k]) begin
					stable_cnt[k] <= '0;
				end else if (tick) begin
					// new level must survive debounce_ticks full ticks
					if (stable_cnt[k] == debounce_ticks) begin
						held[k] <= sync_1[k];
						stable_cnt[k] <= '0;
					end else begin
						stable_cnt[k] <= stable_cnt[k] + 12'd1;
					end
				end
			end
		end
	end

	always_comb begin
		case (held)
			4'b0010: color = color_red;
			4'b0100: color = color_blue;
			4'b1000: color = color_yellow;
			default: color = color_green;
		endcase
	end

	assign buttons = '{held: held, single: $onehot(held), color: color};

endmodule

`default_nettype wire

// File: rtl/sequence_prng.sv
`timescale 1ns/10ps
`default_nettype none

module sequence_prng (
	input  wire  clk,
	input  wire  loser_timer_reset,
	input  wire  randomize,
	input  wire  rerun,
	input  wire  step,
	output simon_pkg::color_t color
);
	import simon_pkg::*;

	logic [15:0] seed;
	logic [15:0] work;

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] r);
		logic fb;
		fb = r[15] ^ r[13] ^ r[12] ^ r[10];
		return {r[14:0], fb};
	endfunction

	always_ff @(posedge clk) begin
		if (loser_timer_reset) begin
			seed <= prng_reset_seed;
			work <= prng_reset_seed;
		end else begin
			if (randomize) begin
				seed <= lfsr_next(seed);
			end
			// rerun restarts the sequence from the stored seed
			if (rerun) begin
				work <= seed;
			end else if (step) begin
				work <= lfsr_next(work);
			end
		end
	end

	assign color = color_t'(work[1:0]);

endmodule

`default_nettype wire

// File: game/simon_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module simon_fsm (
	input  wire  clk,
	input  wire  loser_timer_reset,
	input  wire  simon_pkg::buttons_t buttons,
	input  wire  simon_pkg::color_t prng_color,
	input  wire  timer_done,
	output logic timer_start,
	output simon_pkg::ticks_t timer_length,
	output logic randomize,
	output logic rerun,
	output logic step,
	output simon_pkg::panel_t panel,
	output simon_pkg::round_t round
);
	import simon_pkg::*;

	game_state_t state;
	game_state_t next_state;
	round_t      score;
	logic        score_inc;
	logic        score_clr;
	logic        round_inc;
	logic        round_clr;
	color_t      player_press;
	logic [3:0]  note_idx;
	logic        sounding;

	always_ff @(posedge clk) begin
		if (loser_timer_reset) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (loser_timer_reset) begin
			score <= '0;
			round <= 8'd1;
		end else begin
			if (score_clr) begin
				score <= '0;
			end else if (score_inc) begin
				score <= score + 8'd1;
			end
			if (round_clr) begin
				round <= 8'd1;
			end else if (round_inc) begin
				round <= round + 8'd1;
			end
		end
	end

	// last colour held alone by the player
	always_ff @(posedge clk) begin
		if (buttons.single) begin
			player_press <= buttons.color;
		end
	end

	// fanfare goes note then gap, losing melody goes rest then note
	always_ff @(posedge clk) begin
		if (loser_timer_reset) begin
			note_idx <= '0;
			sounding <= 1'b0;
		end else begin
			case (state)
				st_chk_player: begin
					note_idx <= '0;
					sounding <= 1'b1;
				end
				st_validate: begin
					note_idx <= '0;
					sounding <= 1'b0;
				end
				st_fanfare: begin
					if (timer_done) begin
						sounding <= !sounding;
						if (!sounding) begin
							note_idx <= note_idx + 4'd1;
						end
					end
				end
				st_lose: begin
					if (timer_done) begin
						sounding <= !sounding;
						if (sounding) begin
							note_idx <= note_idx + 4'd1;
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		next_state = state;
		timer_start = 1'b0;
		randomize = 1'b0;
		rerun = 1'b0;
		step = 1'b0;
		score_inc = 1'b0;
		score_clr = 1'b0;
		round_inc = 1'b0;
		round_clr = 1'b0;
		case (state)
			st_idle: begin
				score_clr = 1'b1;
				round_clr = 1'b1;
				if (buttons.held[color_green]) begin
					next_state = st_seed;
				end
			end
			st_seed: begin
				// seed keeps spinning for as long as green is held
				if (buttons.held == 4'b0000) begin
					rerun = 1'b1;
					timer_start = 1'b1;
					next_state = st_gap;
				end else begin
					randomize = 1'b1;
				end
			end
			st_gap: begin
				if (timer_done) begin
					timer_start = 1'b1;
					next_state = st_play;
				end
			end
			st_play: begin
				if (timer_done) begin
					timer_start = 1'b1;
					next_state = st_rest;
				end
			end
			st_rest: begin
				if (timer_done) begin
					step = 1'b1;
					score_inc = 1'b1;
					next_state = st_chk_round;
				end
			end
			st_chk_round: begin
				if (score >= round) begin
					score_clr = 1'b1;
					rerun = 1'b1;
					next_state = st_listen;
				end else begin
					timer_start = 1'b1;
					next_state = st_gap;
				end
			end
			st_listen: begin
				if (buttons.single) begin
					next_state = st_echo;
				end
			end
			st_echo: begin
				if (buttons.held == 4'b0000) begin
					next_state = st_validate;
				end
			end
			st_validate: begin
				if (player_press == prng_color) begin
					score_inc = 1'b1;
					step = 1'b1;
					next_state = st_chk_player;
				end else begin
					timer_start = 1'b1;
					next_state = st_lose;
				end
			end
			st_chk_player: begin
				if (score >= round) begin
					score_clr = 1'b1;
					rerun = 1'b1;
					round_inc = 1'b1;
					timer_start = 1'b1;
					next_state = st_fanfare;
				end else begin
					next_state = st_listen;
				end
			end
			st_fanfare: begin
				if (timer_done) begin
					timer_start = 1'b1;
					if (!sounding && note_idx + 4'd1 == fanfare_notes) begin
						next_state = st_gap;
					end
				end
			end
			st_lose: begin
				if (timer_done) begin
					if (!sounding && note_idx == lose_notes) begin
						next_state = st_idle;
					end else begin
						timer_start = 1'b1;
					end
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_comb begin
		case (state)
			st_play: timer_length = play_note_ticks;
			st_rest: timer_length = play_rest_ticks;
			st_fanfare: timer_length = sounding ? fanfare_note_ticks : fanfare_gap_ticks;
			st_lose: begin
				if (sounding) begin
					timer_length = (note_idx == 4'd0) ? lose_first_ticks : lose_note_ticks;
				end else if (note_idx == 4'd0) begin
					timer_length = end_pause_ticks;
				end else if (note_idx == lose_notes) begin
					// last gap runs straight into the closing pause
					timer_length = lose_gap_ticks + end_pause_ticks;
				end else begin
					timer_length = lose_gap_ticks;
				end
			end
			default: timer_length = play_gap_ticks;
		endcase
	end

	always_comb begin
		panel = '0;
		case (state)
			st_idle: begin
				panel.led_on = 1'b1;
				panel.led_color = color_green;
			end
			st_play: begin
				panel.led_on = 1'b1;
				panel.led_color = prng_color;
				panel.tone_on = 1'b1;
				panel.tone = note_t'(prng_color);
			end
			st_echo: begin
				panel.led_on = buttons.single;
				panel.led_color = buttons.color;
				panel.tone_on = buttons.single;
				panel.tone = note_t'(buttons.color);
			end
			st_fanfare: begin
				panel.led_on = sounding;
				panel.led_color = fanfare_colors[note_idx[1:0]];
				panel.tone_on = sounding;
				panel.tone = note_t'(fanfare_colors[note_idx[1:0]]);
			end
			st_lose: begin
				panel.loser = 1'b1;
				panel.tone_on = sounding;
				if (note_idx < lose_notes) begin
					panel.tone = lose_melody[note_idx];
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/simon_top.sv
`timescale 1ns/10ps
`default_nettype none

module simon_top #(
	parameter int unsigned cycles_per_tick = 50000
) (
	input  wire        clk,
	input  wire        loser_timer_reset,
	input  wire  [3:0] btn_n,
	output simon_pkg::panel_t panel,
	output simon_pkg::round_t round
);
	import simon_pkg::*;

	logic     tick;
	logic     timer_start;
	logic     timer_done;
	ticks_t   timer_length;
	logic     randomize;
	logic     rerun;
	logic     step;
	buttons_t buttons;
	color_t   prng_color;

	game_timer #(
		.cycles_per_tick(cycles_per_tick)
	) u_timer (
		.clk              (clk),
		.loser_timer_reset(loser_timer_reset),
		.start            (timer_start),
		.length           (timer_length),
		.tick             (tick),
		.done             (timer_done)
	);

	button_debouncer u_debounce (
		.clk              (clk),
		.loser_timer_reset(loser_timer_reset),
		.tick             (tick),
		.btn_n            (btn_n),
		.buttons          (buttons)
	);

	sequence_prng u_prng (
		.clk              (clk),
		.loser_timer_reset(loser_timer_reset),
		.randomize        (randomize),
		.rerun            (rerun),
		.step             (step),
		.color            (prng_color)
	);

	simon_fsm u_fsm (
		.clk              (clk),
		.loser_timer_reset(loser_timer_reset),
		.buttons          (buttons),
		.prng_color       (prng_color),
		.timer_done       (timer_done),
		.timer_start      (timer_start),
		.timer_length     (timer_length),
		.randomize        (randomize),
		.rerun            (rerun),
		.step             (step),
		.panel            (panel),
		.round            (round)
	);

endmodule

`default_nettype wire

// File: verification/simon_tb.sv
`timescale 1ns/10ps
`default_nettype none

module simon_tb;
	import simon_pkg::*;

	localparam int cycles_per_tick = 4;
	localparam int max_rounds = 4;
	localparam int min_hold_ticks = debounce_ticks + 4;
	localparam int max_hold_ticks = min_hold_ticks + 15;

	// reference tunes
	localparam color_t fanfare_order [4] = '{color_green, color_red, color_blue, color_yellow};
	localparam note_t losing_tune [10] = '{
		note_b3, note_cs4, note_d4, note_d4, note_d4,
		note_cs4, note_a3, note_cs4, note_cs4, note_b3
	};

	logic clk = 1'b0;
	logic loser_timer_reset;
	logic [3:0] btn_n;
	panel_t panel;
	round_t round;

	int checks = 0;
	int errors = 0;
	logic [31:0] rng = 32'h72c8097e;

	simon_top #(
		.cycles_per_tick(cycles_per_tick)
	) uut (
		.clk              (clk),
		.loser_timer_reset(loser_timer_reset),
		.btn_n            (btn_n),
		.panel            (panel),
		.round            (round)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng >> 8;
	endfunction

	function automatic int hold_length();
		return min_hold_ticks + int'(lcg_next() % 16);
	endfunction

	function automatic longint run_limit_cycles();
		longint ticks;
		ticks = max_hold_ticks + 2 * (debounce_ticks + 2);
		for (int r = 1; r <= max_rounds; r++) begin
			ticks += r * (play_gap_ticks + play_note_ticks + play_rest_ticks);
			ticks += play_rest_ticks + play_gap_ticks + 10;
			ticks += r * (max_hold_ticks + 3 * (debounce_ticks + 2));
			ticks += 4 * (fanfare_note_ticks + fanfare_gap_ticks);
		end
		ticks += 2 * end_pause_ticks + lose_first_ticks + 9 * lose_note_ticks;
		ticks += 10 * lose_gap_ticks;
		return 2 * ticks * cycles_per_tick + 100;
	endfunction

	task automatic compare_value(input string name, input int unsigned got,
			input int unsigned exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic confirm(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR %s", what);
		end
	endtask

	task automatic stay_dark(input int ticks);
		logic dark;
		dark = 1'b1;
		repeat (ticks * cycles_per_tick) begin
			@(negedge clk);
			if (panel.led_on || panel.tone_on) begin
				dark = 1'b0;
			end
		end
		confirm(dark, "LED or tone came on while the game should be silent");
	endtask

	// waits for the next lit LED and follows it until it goes dark
	task automatic next_lit_note(output color_t c, output note_t t);
		do begin
			@(negedge clk);
		end while (!panel.led_on);
		c = panel.led_color;
		t = panel.tone;
		compare_value("panel.tone_on", panel.tone_on, 1);
		do begin
			@(negedge clk);
		end while (panel.led_on);
	endtask

	task automatic start_game(input int hold_ticks);
		@(posedge clk);
		btn_n <= 4'b1110;
		repeat (hold_ticks * cycles_per_tick) @(negedge clk);
		confirm(!panel.led_on, "holding green did not move the game out of idle");
		@(posedge clk);
		btn_n <= 4'b1111;
	endtask

	task automatic press_button(input color_t k, input int hold_ticks, input logic quiet_after);
		@(posedge clk);
		btn_n <= ~(4'b0001 << k);
		repeat (hold_ticks * cycles_per_tick) @(negedge clk);
		compare_value("panel.led_on", panel.led_on, 1);
		compare_value("panel.led_color", panel.led_color, k);
		compare_value("panel.tone_on", panel.tone_on, 1);
		compare_value("panel.tone", panel.tone, k);
		@(posedge clk);
		btn_n <= 4'b1111;
		do begin
			@(negedge clk);
		end while (panel.led_on);
		if (quiet_after) begin
			stay_dark(debounce_ticks);
		end
	endtask

	task automatic follow_losing_melody();
		int notes;
		logic was_on;
		notes = 0;
		was_on = 1'b0;
		do begin
			@(negedge clk);
		end while (!panel.loser);
		while (panel.loser) begin
			if (panel.tone_on && !was_on) begin
				if (notes < 10) begin
					compare_value("panel.tone", panel.tone, losing_tune[notes]);
				end
				notes++;
			end
			was_on = panel.tone_on;
			@(negedge clk);
		end
		compare_value("losing melody length", notes, 10);
	endtask

	// colour k must always sound note k outside the losing melody
	always @(negedge clk) begin
		if (!loser_timer_reset && panel.tone_on && !panel.loser) begin
			assert (panel.led_on && int'(panel.tone) == int'(panel.led_color)) else begin
				errors++;
				$display("MISMATCH panel.tone got 0x%0h expected 0x%0h",
					panel.tone, panel.led_color);
			end
		end
	end

	initial begin
		repeat (run_limit_cycles()) @(posedge clk);
		errors++;
		$display("timeout: the game never finished its losing melody");
		$display("checks: %0d  errors: %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int unsigned wrong_round;
		int unsigned wrong_pos;
		color_t shown [$];
		color_t expected_seq [$];
		color_t c;
		note_t t;
		color_t pick;
		btn_n = 4'b1111;
		loser_timer_reset = 1'b1;
		wrong_round = 2 + lcg_next() % (max_rounds - 1);
		repeat (10) @(posedge clk);
		loser_timer_reset <= 1'b0;
		@(negedge clk);
		compare_value("round", round, 1);
		compare_value("panel.tone_on", panel.tone_on, 0);
		compare_value("panel.loser", panel.loser, 0);
		compare_value("panel.led_on", panel.led_on, 1);
		compare_value("panel.led_color", panel.led_color, color_green);
		start_game(hold_length());
		for (int r = 1; r <= int'(wrong_round); r++) begin
			if (r > 1) begin
				for (int i = 0; i < 4; i++) begin
					next_lit_note(c, t);
					compare_value("fanfare panel.led_color", c, fanfare_order[i]);
				end
			end
			compare_value("round", round, r);
			shown.delete();
			for (int i = 0; i < r; i++) begin
				next_lit_note(c, t);
				compare_value("playback panel.tone", t, c);
				shown.push_back(c);
			end
			// earlier notes repeat the previous round
			for (int i = 0; i < r - 1; i++) begin
				compare_value("playback panel.led_color", shown[i], expected_seq[i]);
			end
			expected_seq = shown;
			stay_dark(play_rest_ticks + play_gap_ticks + 10);
			wrong_pos = lcg_next() % r;
			for (int i = 0; i < r; i++) begin
				if (r == int'(wrong_round) && i == int'(wrong_pos)) begin
					pick = color_t'((int'(expected_seq[i]) + 1 + int'(lcg_next() % 3)) % 4);
					press_button(pick, hold_length(), 1'b0);
					break;
				end
				press_button(expected_seq[i], hold_length(), i != r - 1);
			end
		end
		follow_losing_melody();
		repeat (2) @(negedge clk);
		compare_value("round", round, 1);
		compare_value("panel.led_on", panel.led_on, 1);
		compare_value("panel.led_color", panel.led_color, color_green);
		compare_value("panel.tone_on", panel.tone_on, 0);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
common/simon_pkg.sv
rtl/game_timer.sv
rtl/button_debouncer.sv
rtl/sequence_prng.sv
game/simon_fsm.sv
rtl/simon_top.sv
verification/simon_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= simon_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
